// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - logic

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/pipe_if.sv
      - logic/type_fifo.sv
      - logic/load_dispatch.sv
      - logic/load_pipe.sv
      - logic/line_store.sv
      - logic/resp_merge.sv
      - logic/dcache_top.sv
  - target: simulation
    files:
      - verif/dcache_asserts.sv
      - verif/dcache_tb.sv

// ==== build.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/pipe_if.sv
logic/type_fifo.sv
logic/load_dispatch.sv
logic/load_pipe.sv
logic/line_store.sv
logic/resp_merge.sv
logic/dcache_top.sv
verif/dcache_asserts.sv
verif/dcache_tb.sv

// ==== logic/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// byte address and bus data widths
`define DC_ADDR_W 16
`define DC_DATA_W 32

// line storage geometry, 64 lines of 16 bytes
`define DC_LINE_BYTES 16
`define DC_LINES 64

// load pipelines and queue depth
`define DC_PIPES 2
`define DC_FIFO_DEPTH 4

`endif

// ==== logic/dcache_pkg.sv ====
`include "dcache_params.svh"

package dcache_pkg;

    // one load as issued to a pipeline
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
    } load_req_t;

    // AXI response codes in use
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axi_resp_e;

    // one load result
    typedef struct packed {
        logic [`DC_DATA_W-1:0] data;
        axi_resp_e             resp;
    } load_resp_t;

    typedef logic [`DC_LINE_BYTES*8-1:0] line_t;

endpackage

// ==== logic/dcache_top.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    // read address and data
    input  logic [`DC_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`DC_DATA_W-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // write address, data and response
    input  logic [`DC_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`DC_DATA_W-1:0]   wdata,
    input  logic [`DC_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready
);
    logic                         rd_en   [`DC_PIPES];
    logic [$clog2(`DC_LINES)-1:0] rd_idx  [`DC_PIPES];
    line_t                        rd_line [`DC_PIPES];

    pipe_if pipes [`DC_PIPES] ();

    load_dispatch dispatch_i (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .pipes   (pipes)
    );

    for (genvar g = 0; g < `DC_PIPES; g++) begin : gen_pipe
        load_pipe pipe_i (
            .clk     (clk),
            .rst     (rst),
            .port    (pipes[g]),
            .rd_en   (rd_en[g]),
            .rd_idx  (rd_idx[g]),
            .rd_line (rd_line[g])
        );
    end

    line_store store_i (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_line (rd_line)
    );

    resp_merge merge_i (
        .clk    (clk),
        .rst    (rst),
        .pipes  (pipes),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready)
    );

endmodule

// ==== logic/line_store.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module line_store
    import dcache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`DC_ADDR_W-1:0]        awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`DC_DATA_W-1:0]        wdata,
    input  logic [`DC_DATA_W/8-1:0]      wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic                         rd_en   [`DC_PIPES],
    input  logic [$clog2(`DC_LINES)-1:0] rd_idx  [`DC_PIPES],
    output line_t                        rd_line [`DC_PIPES]
);
    localparam int OFF_W  = $clog2(`DC_LINE_BYTES);
    localparam int IDX_W  = $clog2(`DC_LINES);
    localparam int WORD_W = $clog2(`DC_LINE_BYTES * 8 / `DC_DATA_W);
    localparam int STRB_W = `DC_DATA_W / 8;
    localparam logic [`DC_ADDR_W-1:0] ADDR_LIMIT = `DC_LINES * `DC_LINE_BYTES;

    line_t             mem [`DC_LINES];
    logic              wr_rdy;
    logic              wr_fire;
    logic              wr_in_range;
    logic [IDX_W-1:0]  wr_idx;
    logic [WORD_W-1:0] wr_word;

    // AW and W are taken together, one write outstanding
    assign awready     = wr_rdy && awvalid && wvalid;
    assign wready      = awready;
    assign wr_fire     = awready;
    assign wr_in_range = (awaddr < ADDR_LIMIT);
    assign wr_idx      = awaddr[OFF_W +: IDX_W];
    assign wr_word     = awaddr[OFF_W-1 -: WORD_W];

    always_ff @(posedge clk) begin
        if (wr_fire && wr_in_range) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][(wr_word * STRB_W + b) * 8 +: 8] <= wdata[b * 8 +: 8];
                end
            end
        end
    end

    for (genvar p = 0; p < `DC_PIPES; p++) begin : gen_rd
        always_ff @(posedge clk) begin
            if (rd_en[p]) begin
                rd_line[p] <= mem[rd_idx[p]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_rdy <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            wr_rdy <= !wr_fire && !(bvalid && !bready);
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_in_range ? OKAY : SLVERR;
        end
    end

endmodule

// ==== logic/load_dispatch.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module load_dispatch
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`DC_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    pipe_if.dispatch              pipes [`DC_PIPES]
);
    localparam int CNT_W = $clog2(`DC_FIFO_DEPTH + 1);
    localparam int SEL_W = (`DC_PIPES > 1) ? $clog2(`DC_PIPES) : 1;

    load_req_t            ar_req;
    load_req_t            q_head;
    logic                 q_empty;
    logic [CNT_W-1:0]     q_count;
    logic [CNT_W-1:0]     next_cnt;
    logic [SEL_W-1:0]     sel;
    logic [`DC_PIPES-1:0] ready_vec;
    logic                 ar_fire;
    logic                 req_fire;

    assign ar_req   = '{addr: araddr};
    assign ar_fire  = arvalid && arready;
    assign req_fire = !q_empty && ready_vec[sel];
    assign next_cnt = q_count + CNT_W'(ar_fire) - CNT_W'(req_fire);

    type_fifo #(
        .payload_t (load_req_t),
        .DEPTH     (`DC_FIFO_DEPTH)
    ) req_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (ar_fire),
        .push_data (ar_req),
        .full      (),
        .pop       (req_fire),
        .pop_data  (q_head),
        .empty     (q_empty),
        .count     (q_count)
    );

    // queue head goes only to the pipe whose turn it is
    for (genvar p = 0; p < `DC_PIPES; p++) begin : gen_issue
        assign pipes[p].req_valid = !q_empty && (sel == SEL_W'(p));
        assign pipes[p].req       = q_head;
        assign ready_vec[p]       = pipes[p].req_ready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            sel     <= '0;
        end else begin
            arready <= (next_cnt != CNT_W'(`DC_FIFO_DEPTH));
            if (req_fire) begin
                sel <= (sel == SEL_W'(`DC_PIPES - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

endmodule

// ==== logic/load_pipe.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module load_pipe
    import dcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    pipe_if.pipe                        port,
    output logic                        rd_en,
    output logic [$clog2(`DC_LINES)-1:0] rd_idx,
    input  line_t                       rd_line
);
    localparam int OFF_W  = $clog2(`DC_LINE_BYTES);
    localparam int IDX_W  = $clog2(`DC_LINES);
    localparam int WORD_W = $clog2(`DC_LINE_BYTES * 8 / `DC_DATA_W);
    localparam int CNT_W  = $clog2(`DC_FIFO_DEPTH + 1);
    localparam logic [`DC_ADDR_W-1:0] ADDR_LIMIT = `DC_LINES * `DC_LINE_BYTES;

    logic                  s1_valid;
    logic [`DC_ADDR_W-1:0] s1_addr;
    logic                  s1_fault;
    logic                  s2_valid;
    logic                  s2_fault;
    logic [WORD_W-1:0]     s2_word;
    load_resp_t            s2_resp;
    logic [1:0]            in_flight;
    logic [CNT_W-1:0]      q_count;
    logic                  q_empty;

    // credits cover s1, s2 and the queue
    assign in_flight      = 2'(s1_valid) + 2'(s2_valid);
    assign port.req_ready = (int'(in_flight) + int'(q_count)) < `DC_FIFO_DEPTH;

    // s1: range check and line read
    assign s1_fault = (s1_addr >= ADDR_LIMIT);
    assign rd_en    = s1_valid && !s1_fault;
    assign rd_idx   = s1_addr[OFF_W +: IDX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= port.req_valid && port.req_ready;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr  <= port.req.addr;
        s2_fault <= s1_fault;
        s2_word  <= s1_addr[OFF_W-1 -: WORD_W];
    end

    // s2: word select, faulting loads read as zero
    assign s2_resp.data = s2_fault ? '0 : rd_line[s2_word * `DC_DATA_W +: `DC_DATA_W];
    assign s2_resp.resp = s2_fault ? SLVERR : OKAY;

    type_fifo #(
        .payload_t (load_resp_t),
        .DEPTH     (`DC_FIFO_DEPTH)
    ) resp_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (s2_valid),
        .push_data (s2_resp),
        .full      (),
        .pop       (port.resp_ready),
        .pop_data  (port.resp),
        .empty     (q_empty),
        .count     (q_count)
    );

    assign port.resp_valid = !q_empty;

endmodule

// ==== logic/pipe_if.sv ====
`timescale 1ns/100ps

interface pipe_if
    import dcache_pkg::*;
();
    // dispatcher to pipeline
    logic       req_valid;
    logic       req_ready;
    load_req_t  req;

    // pipeline to merge block
    logic       resp_valid;
    logic       resp_ready;
    load_resp_t resp;

    modport dispatch (output req_valid, output req, input req_ready);

    modport pipe (
        input  req_valid, input  req, output req_ready,
        output resp_valid, output resp, input  resp_ready
    );

    modport merge (input resp_valid, input resp, output resp_ready);

endinterface

// ==== logic/resp_merge.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module resp_merge
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    pipe_if.merge                 pipes [`DC_PIPES],
    output logic [`DC_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready
);
    localparam int SEL_W = (`DC_PIPES > 1) ? $clog2(`DC_PIPES) : 1;

    logic [SEL_W-1:0]     sel;
    logic [`DC_PIPES-1:0] valid_vec;
    load_resp_t           resp_vec [`DC_PIPES];
    logic                 take;
    logic                 fire;

    // output register free or draining this cycle
    assign take = !rvalid || rready;
    assign fire = take && valid_vec[sel];

    for (genvar p = 0; p < `DC_PIPES; p++) begin : gen_collect
        assign valid_vec[p]        = pipes[p].resp_valid;
        assign resp_vec[p]         = pipes[p].resp;
        assign pipes[p].resp_ready = take && (sel == SEL_W'(p));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            sel    <= '0;
        end else begin
            if (fire) begin
                rvalid <= 1'b1;
                sel    <= (sel == SEL_W'(`DC_PIPES - 1)) ? '0 : sel + 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            rdata <= resp_vec[sel].data;
            rresp <= resp_vec[sel].resp;
        end
    end

endmodule

// ==== logic/type_fifo.sv ====
`timescale 1ns/100ps

module type_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  payload_t                   push_data,
    output logic                       full,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    // head is visible without a pop
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// ==== verif/dcache_asserts.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  arready,
    input logic                  rvalid,
    input logic [`DC_DATA_W-1:0] rdata,
    input logic                  rready,
    input logic                  bvalid,
    input logic                  bready
);
    int fail_cnt = 0;

    // R beat is held until taken
    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        fail_cnt++;
        $error("rvalid or rdata changed while rready was low");
    end

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
    else begin
        fail_cnt++;
        $error("bvalid dropped while bready was low");
    end

    // registers cleared by the reset edge
    reset_quiet: assert property (@(posedge clk)
        rst |=> !arready && !rvalid && !bvalid)
    else begin
        fail_cnt++;
        $error("arready, rvalid or bvalid high during reset");
    end

endmodule

bind dcache_top dcache_asserts asserts_i (.*);

// ==== verif/dcache_tb.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_tb
    import dcache_pkg::*;
();
    localparam int N_FILL      = 256;
    localparam int N_PARTIAL   = 32;
    localparam int N_OOR       = 8;
    localparam int N_BURSTS    = 4;
    localparam int BURST_LEN   = 16;
    localparam int N_THROTTLE  = 64;
    localparam int N_OPS       = 2 * N_FILL + 2 * N_PARTIAL + 3 * N_OOR
                                 + N_BURSTS * BURST_LEN + N_THROTTLE;
    localparam int TIMEOUT_CYC = 60 * N_OPS + 500;
    localparam int ADDR_LIMIT  = `DC_LINES * `DC_LINE_BYTES;

    logic                    clk;
    logic                    rst;
    logic [`DC_ADDR_W-1:0]   araddr;
    logic                    arvalid;
    logic                    arready;
    logic [`DC_DATA_W-1:0]   rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    logic [`DC_ADDR_W-1:0]   awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [`DC_DATA_W-1:0]   wdata;
    logic [`DC_DATA_W/8-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;

    integer     seed = 22050;
    int         cycles = 0;
    logic       throttle = 1'b0;
    logic       ar_stalled = 1'b0;
    logic [7:0] shadow [ADDR_LIMIT];
    load_resp_t exp_q [$];
    load_resp_t exp_resp;

    dcache_top dcache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    // little endian word from the shadow bytes
    function automatic load_resp_t exp_read(input logic [`DC_ADDR_W-1:0] addr);
        load_resp_t r;
        int         base;
        base = int'(addr) & ~3;
        if (int'(addr) >= ADDR_LIMIT) begin
            r.data = '0;
            r.resp = SLVERR;
        end else begin
            r.data = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
            r.resp = OKAY;
        end
        return r;
    endfunction

    task automatic drain_loads();
        @(negedge clk);
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic store_word(input logic [`DC_ADDR_W-1:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int base;
        base = int'(addr) & ~3;
        // no load may still be reading the line
        drain_loads();
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge clk); while (!awready);
        check_val(wready, 1'b1, "wready");
        if (int'(addr) < ADDR_LIMIT) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[base + b] = data[b * 8 +: 8];
            end
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // hold B off for a few cycles now and then
        bready  = 1'b0;
        repeat ($random(seed) & 3) @(negedge clk);
        bready  = 1'b1;
        do @(posedge clk); while (!(bvalid && bready));
        check_val(bresp, (int'(addr) < ADDR_LIMIT) ? OKAY : SLVERR, "bresp");
    endtask

    task automatic issue_load(input logic [`DC_ADDR_W-1:0] addr);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            @(posedge clk);
            if (!arready && throttle) ar_stalled = 1'b1;
        end while (!arready);
        exp_q.push_back(exp_read(addr));
    endtask

    task automatic end_burst();
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    // compare each R beat against the oldest expected load
    always @(posedge clk) begin
        if (!rst && rvalid && rready) begin
            if (exp_q.size() == 0) begin
                abort_run("a read response arrived with no load outstanding");
            end else begin
                exp_resp = exp_q.pop_front();
                check_val(rdata, exp_resp.data, "rdata");
                check_val(rresp, exp_resp.resp, "rresp");
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (dcache_top_i.asserts_i.fail_cnt != 0) begin
            abort_run("a bound assertion on the AXI handshakes failed");
        end else if (cycles >= TIMEOUT_CYC) begin
            abort_run($sformatf("timeout after %0d cycles, %0d read responses never arrived",
                                cycles, exp_q.size()));
        end
    end

    // back-pressure on R, mostly low while throttled
    always @(negedge clk) begin
        if (throttle) rready = (($random(seed) & 3) == 0);
        else rready = 1'b1;
    end

    initial begin
        rst = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // full words everywhere, each read back after its write response
        for (int w = 0; w < N_FILL; w++) begin
            store_word(16'(w * 4), $random(seed), 4'hf);
            issue_load(16'(w * 4));
            end_burst();
        end
        for (int i = 0; i < N_PARTIAL; i++) begin
            store_word(16'($random(seed)) & 16'h03fc, $random(seed), 4'($random(seed)));
            issue_load(awaddr);
            end_burst();
        end
        // beyond the storage
        for (int i = 0; i < N_OOR; i++) begin
            store_word(16'($random(seed)) | 16'h0400, $random(seed), 4'hf);
            // the aliased in-range word stays as it was
            issue_load(awaddr & 16'h03ff);
            issue_load(16'($random(seed)) | 16'h0400);
            end_burst();
        end
        for (int k = 0; k < N_BURSTS; k++) begin
            for (int i = 0; i < BURST_LEN; i++) issue_load(16'($random(seed)) & 16'h03ff);
            end_burst();
        end
        drain_loads();
        @(posedge clk);
        throttle = 1'b1;
        for (int i = 0; i < N_THROTTLE; i++) issue_load(16'($random(seed)) & 16'h03ff);
        end_burst();
        if (!ar_stalled) abort_run("arready never fell while rready was held low");
        @(posedge clk);
        throttle = 1'b0;
        drain_loads();
        // late or duplicate beats show up in the comparing process
        repeat (20) @(negedge clk);
        if (dcache_top_i.asserts_i.fail_cnt != 0) begin
            abort_run($sformatf("%0d bound assertion failures",
                                dcache_top_i.asserts_i.fail_cnt));
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
